// File: src/imuldiv_pkg.sv
/*
  shared types for the iterative divider, width fixed at 32 by the structs
  request and status layouts are shared by control, datapath and testbench
*/
package imuldiv_pkg;

  // operand width, results are twice this wide
  localparam int div_width = 32;

  // ------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------

  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_t;

  // ------------------------------------------------------------
  // messages and internal control
  // ------------------------------------------------------------

  // request message, 65 bits: fn, dividend, divisor
  typedef struct packed {
    div_fn_t              fn;
    logic [div_width-1:0] a;
    logic [div_width-1:0] b;
  } div_req_t;

  // control word from the FSM into the datapath
  typedef struct packed {
    logic a_en;         // load remainder/quotient register
    logic b_en;         // load divisor register
    logic a_mux_sel;    // 1 takes the iteration result, 0 the initial dividend
    logic sub_mux_sel;  // 1 restores the shifted value, 0 keeps the difference
    logic op_load;      // capture fn and operand signs, reload counter
  } div_ctrl_t;

  // status from the datapath back to the FSM
  typedef struct packed {
    logic sub_neg;          // sign of the trial subtraction
    logic counter_is_zero;  // all quotient bits have been produced
  } div_status_t;

endpackage

// File: src/int_div_ctrl.sv
/*
  idle/calc/done FSM for the divider, one request in flight
  done holds until the response handshake, req_rdy only in idle
*/
module int_div_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  input  imuldiv_pkg::div_status_t  status,
  output imuldiv_pkg::div_ctrl_t    ctrl
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;

  logic req_go;
  logic resp_go;

  // ------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------------------------------------
  // next state and datapath controls
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    ctrl    = '0;

    case (state_q)
      st_idle: begin
        // load operands, magnitudes and signs on acceptance
        if (req_go) begin
          ctrl.a_en      = 1'b1;
          ctrl.b_en      = 1'b1;
          ctrl.op_load   = 1'b1;
          ctrl.a_mux_sel = 1'b0;
          state_d        = st_calc;
        end
      end

      st_calc: begin
        // one quotient bit per cycle until the counter runs out
        ctrl.a_mux_sel   = 1'b1;
        ctrl.sub_mux_sel = status.sub_neg;
        if (status.counter_is_zero) begin
          // transfer cycle, result already held
          state_d = st_done;
        end else begin
          ctrl.a_en = 1'b1;
        end
      end

      st_done: begin
        // result stays put while the consumer stalls
        if (resp_go) begin
          state_d = st_idle;
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: src/int_div_dpath.sv
/*
  restoring divider datapath, one quotient bit per enabled cycle
  signed operands are reduced to magnitudes at load, signs fixed at the output
*/
module int_div_dpath (
  input  logic                                 clk,
  input  logic                                 reset,
  input  imuldiv_pkg::div_req_t                req_msg,
  input  imuldiv_pkg::div_ctrl_t               ctrl,
  output imuldiv_pkg::div_status_t             status,
  output logic [2*imuldiv_pkg::div_width-1:0]  resp_msg
);

  localparam int w  = imuldiv_pkg::div_width;
  localparam int cw = $clog2(w);

  // ------------------------------------------------------------
  // operand preparation
  // ------------------------------------------------------------

  logic         req_signed;
  logic [w-1:0] a_mag;
  logic [w-1:0] b_mag;
  logic [2*w:0] a_initial;
  logic [2*w:0] b_initial;

  assign req_signed = (req_msg.fn == imuldiv_pkg::div_fn_signed);

  // two's complement magnitude, only for signed requests
  assign a_mag = (req_signed && req_msg.a[w-1]) ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag = (req_signed && req_msg.b[w-1]) ? (~req_msg.b + 1'b1) : req_msg.b;

  // dividend sits in the low half, divisor aligned to the remainder half
  assign a_initial = {{(w+1){1'b0}}, a_mag};
  assign b_initial = {1'b0, b_mag, {w{1'b0}}};

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  // a_q holds {remainder, quotient} with one spare top bit for the sign
  logic [2*w:0]  a_q;
  logic [2*w:0]  b_q;
  logic          fn_signed_q;
  logic          a_sign_q;
  logic          b_sign_q;
  logic [cw-1:0] counter_q;
  logic          iter_done_q;

  // ------------------------------------------------------------
  // shift and subtract
  // ------------------------------------------------------------

  logic [2*w:0] a_shift;
  logic [2*w:0] sub_out;
  logic [2*w:0] sub_keep;
  logic [2*w:0] sub_restore;
  logic [2*w:0] sub_mux_out;
  logic [2*w:0] a_mux_out;
  logic         iterate;

  assign a_shift = {a_q[2*w-1:0], 1'b0};
  assign sub_out = a_shift - b_q;

  // difference fits, quotient bit is one
  assign sub_keep    = {sub_out[2*w:1], 1'b1};
  // divisor too large, go back to the shifted value with quotient bit zero
  assign sub_restore = {a_shift[2*w:1], 1'b0};

  assign sub_mux_out = ctrl.sub_mux_sel ? sub_restore : sub_keep;
  assign a_mux_out   = ctrl.a_mux_sel ? sub_mux_out : a_initial;

  assign iterate = ctrl.a_en && ctrl.a_mux_sel;

  // operand, remainder/quotient and sign registers
  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_q <= a_mux_out;
    end
    if (ctrl.b_en) begin
      b_q <= b_initial;
    end
    if (ctrl.op_load) begin
      fn_signed_q <= req_signed;
      a_sign_q    <= req_msg.a[w-1];
      b_sign_q    <= req_msg.b[w-1];
    end
  end

  // iteration counter, runs 31 down to 0 then flags completion
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_q   <= '0;
      iter_done_q <= 1'b0;
    end else if (ctrl.op_load) begin
      counter_q   <= cw'(w - 1);
      iter_done_q <= 1'b0;
    end else if (iterate) begin
      counter_q <= counter_q - 1'b1;
      // the pass with counter at zero produced the last quotient bit
      if (counter_q == '0) begin
        iter_done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    status.sub_neg         = sub_out[2*w];
    status.counter_is_zero = iter_done_q;
  end

  // ------------------------------------------------------------
  // sign correction
  // ------------------------------------------------------------

  logic [w-1:0] quot_mag;
  logic [w-1:0] rem_mag;
  logic         quot_neg;
  logic         rem_neg;
  logic [w-1:0] quot_out;
  logic [w-1:0] rem_out;

  assign quot_mag = a_q[w-1:0];
  assign rem_mag  = a_q[2*w-1:w];

  // quotient negative when exactly one operand was negative
  assign quot_neg = fn_signed_q && (a_sign_q ^ b_sign_q);
  // remainder follows the dividend
  assign rem_neg  = fn_signed_q && a_sign_q;

  assign quot_out = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  assign resp_msg = {rem_out, quot_out};

endmodule

// File: src/int_div_iterative.sv
/*
  iterative 32-bit divider, result is {remainder, quotient}
  response 33 cycles after acceptance, no new request until it is taken
*/
module int_div_iterative (
  input  logic                                 clk,
  input  logic                                 reset,
  input  imuldiv_pkg::div_req_t                req_msg,
  input  logic                                 req_val,
  output logic                                 req_rdy,
  output logic [2*imuldiv_pkg::div_width-1:0]  resp_msg,
  output logic                                 resp_val,
  input  logic                                 resp_rdy
);

  // control word and status between FSM and datapath
  imuldiv_pkg::div_ctrl_t   ctrl;
  imuldiv_pkg::div_status_t status;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  int_div_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .status   (status),
    .ctrl     (ctrl)
  );

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  int_div_dpath dpath_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .ctrl     (ctrl),
    .status   (status),
    .resp_msg (resp_msg)
  );

endmodule

// File: test/int_div_assert.sv
/*
  handshake and latency assertions for int_div_iterative, bound from the testbench
  the latency figure assumes the fixed 32-pass restoring loop
*/
module int_div_assert (
  input logic                                clk,
  input logic                                reset,
  input logic                                req_val,
  input logic                                req_rdy,
  input logic [2*imuldiv_pkg::div_width-1:0] resp_msg,
  input logic                                resp_val,
  input logic                                resp_rdy
);

  // one edge per quotient bit plus the transfer into done
  localparam int resp_delay = imuldiv_pkg::div_width + 1;

  // per-property failure counters, summed for the testbench summary
  int unsigned excl_fails   = 0;
  int unsigned hold_fails   = 0;
  int unsigned rise_fails   = 0;
  int unsigned origin_fails = 0;
  int unsigned reset_fails  = 0;
  int unsigned fail_count;

  logic req_go;

  assign req_go     = req_val && req_rdy;
  assign fail_count = excl_fails + hold_fails + rise_fails + origin_fails + reset_fails;

  // ------------------------------------------------------------
  // handshake protocol
  // ------------------------------------------------------------

  // idle and done are distinct states
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val))
    else begin
      excl_fails++;
      $error("req_rdy and resp_val high in the same cycle");
    end

  // a stalled response keeps its value
  assert property (@(posedge clk) disable iff (reset)
                   (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)))
    else begin
      hold_fails++;
      $error("resp_val dropped or resp_msg changed before resp_rdy");
    end

  // ------------------------------------------------------------
  // latency
  // ------------------------------------------------------------

  // accepting edge followed by exactly resp_delay edges to resp_val
  assert property (@(posedge clk) disable iff (reset) req_go |=> ##resp_delay $rose(resp_val))
    else begin
      rise_fails++;
      $error("resp_val did not rise at the expected edge after acceptance");
    end

  // and no response shows up without a request that far back
  assert property (@(posedge clk) disable iff (reset)
                   $rose(resp_val) |-> $past(req_go, resp_delay + 1))
    else begin
      origin_fails++;
      $error("resp_val rose without a matching accepted request");
    end

  // ------------------------------------------------------------
  // reset
  // ------------------------------------------------------------

  assert property (@(posedge clk) reset |=> (req_rdy && !resp_val))
    else begin
      reset_fails++;
      $error("unit not idle in the cycle after reset");
    end

endmodule

// File: test/int_div_tb.sv
/*
  testbench for int_div_iterative, expected results come from the division rules
  inputs change on the falling edge, outputs are sampled there too
*/
module int_div_tb;

  localparam int w             = imuldiv_pkg::div_width;
  localparam int timeout_cycles = 100;
  localparam int latency        = 33;

  logic                  clk;
  logic                  reset;
  imuldiv_pkg::div_req_t req_msg;
  logic                  req_val;
  logic                  req_rdy;
  logic [2*w-1:0]        resp_msg;
  logic                  resp_val;
  logic                  resp_rdy;

  // bookkeeping
  int          err_count = 0;
  int          test_err_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  bit          hung = 1'b0;
  logic [31:0] rng = 32'h00fc_9549;
  logic [w-1:0] op_a;
  logic [w-1:0] op_b;
  int          stall;

  int_div_iterative dut_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  bind int_div_iterative int_div_assert assert_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // divide magnitudes, then quotient sign from the xor, remainder sign from the dividend
  function automatic logic [2*w-1:0] expected_result(input imuldiv_pkg::div_fn_t fn,
                                                     input logic [w-1:0] a,
                                                     input logic [w-1:0] b);
    logic         a_neg;
    logic         b_neg;
    logic [w-1:0] a_abs;
    logic [w-1:0] b_abs;
    logic [w-1:0] q;
    logic [w-1:0] r;
    a_neg = (fn == imuldiv_pkg::div_fn_signed) && a[w-1];
    b_neg = (fn == imuldiv_pkg::div_fn_signed) && b[w-1];
    a_abs = a_neg ? -a : a;
    b_abs = b_neg ? -b : b;
    if (b_abs == '0) begin
      // divide by zero: all-ones quotient, dividend left over
      q = '1;
      r = a_abs;
    end else begin
      q = a_abs / b_abs;
      r = a_abs % b_abs;
    end
    if (a_neg != b_neg) begin
      q = -q;
    end
    if (a_neg) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles, skipping the remaining work", what,
             timeout_cycles);
    err_count++;
    hung = 1'b1;
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_err_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  // one division, optionally stalling the response for some cycles
  task automatic run_div(input imuldiv_pkg::div_fn_t fn, input logic [w-1:0] a,
                         input logic [w-1:0] b, input int hold);
    logic [2*w-1:0] expected;
    logic [2*w-1:0] held;
    int             waited;
    if (hung) begin
      return;
    end
    expected    = expected_result(fn, a, b);
    req_msg.fn  = fn;
    req_msg.a   = a;
    req_msg.b   = b;
    req_val     = 1'b1;
    resp_rdy    = (hold == 0);
    waited      = 0;
    while (!req_rdy && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      report_timeout("req_rdy");
      return;
    end
    // accepted on the rising edge just before this falling edge
    @(negedge clk);
    req_val = 1'b0;
    // rising edges counted from the accepting edge
    waited  = 0;
    while (!resp_val && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_val) begin
      report_timeout("resp_val");
      return;
    end
    check_equal("latency", latency, waited);
    check_equal("resp_msg", expected, resp_msg);
    if (hold > 0) begin
      held = resp_msg;
      // a competing request while done holds
      rng         = xorshift32(rng);
      req_msg.a   = rng;
      req_msg.b   = ~rng;
      req_val     = 1'b1;
      repeat (hold) begin
        @(negedge clk);
        check_equal("req_rdy", 0, req_rdy);
        check_equal("resp_msg", held, resp_msg);
      end
      req_val  = 1'b0;
      resp_rdy = 1'b1;
    end
    // handshake edge passes, idle again right after
    @(negedge clk);
    check_equal("req_rdy", 1, req_rdy);
    check_equal("resp_val", 0, resp_val);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_equal("req_rdy", 1, req_rdy);
    check_equal("resp_val", 0, resp_val);
    repeat (10) begin
      @(negedge clk);
      check_equal("resp_val", 0, resp_val);
    end
    finish_test("reset state");

    run_div(imuldiv_pkg::div_fn_unsigned, 32'd7, 32'd2, 0);
    run_div(imuldiv_pkg::div_fn_unsigned, 32'hffff_ffff, 32'd1, 0);
    run_div(imuldiv_pkg::div_fn_unsigned, 32'd0, 32'd5, 0);
    run_div(imuldiv_pkg::div_fn_unsigned, 32'd9, 32'h8000_0001, 0);
    repeat (40) begin
      rng  = xorshift32(rng);
      op_a = rng;
      rng  = xorshift32(rng);
      // varying shift gives both small and large divisors
      op_b = rng >> op_a[4:0];
      run_div(imuldiv_pkg::div_fn_unsigned, op_a, op_b, 0);
    end
    finish_test("unsigned division");

    run_div(imuldiv_pkg::div_fn_signed, 32'd7, 32'd2, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'hffff_fff9, 32'd2, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'd7, 32'hffff_fffe, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'hffff_fff9, 32'hffff_fffe, 0);
    repeat (30) begin
      rng  = xorshift32(rng);
      op_a = rng;
      rng  = xorshift32(rng);
      op_b = $unsigned($signed(rng) >>> op_a[4:0]);
      run_div(imuldiv_pkg::div_fn_signed, op_a, op_b, 0);
    end
    finish_test("signed division");

    run_div(imuldiv_pkg::div_fn_unsigned, 32'h1234_5678, 32'd0, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'd100, 32'd0, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'hffff_fff9, 32'd0, 0);
    run_div(imuldiv_pkg::div_fn_signed, 32'h8000_0000, 32'hffff_ffff, 0);
    finish_test("corner cases");

    repeat (8) begin
      rng   = xorshift32(rng);
      op_a  = rng;
      rng   = xorshift32(rng);
      op_b  = rng >> 20;
      rng   = xorshift32(rng);
      stall = int'(rng % 32'd21);
      run_div(rng[31] ? imuldiv_pkg::div_fn_signed : imuldiv_pkg::div_fn_unsigned,
              op_a, op_b, stall);
    end
    run_div(imuldiv_pkg::div_fn_unsigned, 32'd1000, 32'd3, 20);
    finish_test("back-pressure");

    $display("summary: %0d tests passed, %0d tests failed, %0d check errors, %0d assertion failures",
             tests_passed, tests_failed, err_count, dut_i.assert_i.fail_count);
    if (tests_failed == 0 && err_count == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/imuldiv_pkg.sv
src/int_div_ctrl.sv
src/int_div_dpath.sv
src/int_div_iterative.sv
test/int_div_assert.sv
test/int_div_tb.sv

// File: Makefile
# Verilator build and run for the iterative divider

VERILATOR ?= verilator
TOP       ?= int_div_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
